//--- hdl/touch_defs.svh
`ifndef TOUCH_DEFS_SVH
`define TOUCH_DEFS_SVH

// calibration offsets in raw touchpad units
// subtracted before scaling to pixels
`define TOUCH_X_OFFSET 150
`define TOUCH_Y_OFFSET 300

// raw units to pixels, divide by four
`define TOUCH_SCALE_SHIFT 2

// pressure bits dropped before the presence test
// so anything below 256 counts as released
`define TOUCH_Z_SHIFT 8

// visible panel size in pixels
// outputs never go past width-1 / height-1
`define SCREEN_WIDTH 480
`define SCREEN_HEIGHT 272

// consecutive pressed frames before a touch is reported
`define DEBOUNCE_FRAMES 2

`endif

//--- hdl/touch_pkg.sv
package touch_pkg;

	// every touchpad channel is a 12-bit conversion
	localparam int TOUCH_DATA_W = 12;

	// touch or screen coordinate
	typedef logic [TOUCH_DATA_W-1:0] coord_t;

	// raw pressure reading
	typedef logic [TOUCH_DATA_W-1:0] pressure_t;

	// one raw sample from the touchpad controller
	typedef struct packed {
		coord_t x;
		coord_t y;
		pressure_t z;
	} touch_sample_t;

	// position plus touched level, passed between stages
	typedef struct packed {
		coord_t x;
		coord_t y;
		logic touched;
	} touch_point_t;

endpackage

//--- hdl/touch_presence_detect.sv
`include "touch_defs.svh"

module touch_presence_detect (
	input logic tft_new_frame,
	input logic rst_n,
	input touch_pkg::touch_sample_t raw_sample,
	output touch_pkg::touch_point_t pressed_point
);

	import touch_pkg::*;

	// counter has to be able to hold DEBOUNCE_FRAMES itself
	localparam int DEB_W = $clog2(`DEBOUNCE_FRAMES + 1);
	localparam logic [DEB_W-1:0] DEB_TARGET = DEB_W'(`DEBOUNCE_FRAMES);

	pressure_t z_high;
	logic pressed_now;
	logic [DEB_W-1:0] press_count;
	logic [DEB_W-1:0] count_next;
	logic touched_next;

	// presence test on the upper pressure bits only
	assign z_high = raw_sample.z >> `TOUCH_Z_SHIFT;
	assign pressed_now = (z_high != '0);

	// saturating run length of pressed frames
	always_comb begin
		if (!pressed_now) begin
			count_next = '0;
		end else if (press_count < DEB_TARGET) begin
			count_next = press_count + 1'b1;
		end else begin
			count_next = press_count;
		end
	end

	// touched rises on the frame that completes the run
	assign touched_next = pressed_now && (count_next >= DEB_TARGET);

	always_ff @(posedge tft_new_frame) begin
		if (!rst_n) begin
			press_count <= '0;
		end else begin
			press_count <= count_next;
		end
	end

	// raw coordinates go on unchanged, stage 2 does the mapping
	always_ff @(posedge tft_new_frame) begin
		if (!rst_n) begin
			pressed_point.x <= '0;
			pressed_point.y <= '0;
			pressed_point.touched <= 1'b0;
		end else begin
			pressed_point.x <= raw_sample.x;
			pressed_point.y <= raw_sample.y;
			pressed_point.touched <= touched_next;
		end
	end

endmodule

//--- hdl/touch_offset_scale.sv
`include "touch_defs.svh"

module touch_offset_scale (
	input logic tft_new_frame,
	input logic rst_n,
	input touch_pkg::touch_point_t pressed_point,
	output touch_pkg::touch_point_t scaled_point
);

	import touch_pkg::*;

	localparam coord_t X_OFFSET = coord_t'(`TOUCH_X_OFFSET);
	localparam coord_t Y_OFFSET = coord_t'(`TOUCH_Y_OFFSET);

	// last visible column and row
	localparam coord_t X_LAST = coord_t'(`SCREEN_WIDTH - 1);
	localparam coord_t Y_LAST = coord_t'(`SCREEN_HEIGHT - 1);

	coord_t x_mapped;
	coord_t y_mapped;

	// raw axis value to pixel index
	// below the offset pins to zero rather than wrapping round
	function automatic coord_t map_axis(
		input coord_t raw,
		input coord_t offset,
		input coord_t last
	);
		coord_t shifted;
		coord_t scaled;
		if (raw < offset) begin
			shifted = '0;
		end else begin
			shifted = raw - offset;
		end
		scaled = shifted >> `TOUCH_SCALE_SHIFT;
		// top of the raw range lands well off the panel
		if (scaled > last) begin
			return last;
		end
		return scaled;
	endfunction

	assign x_mapped = map_axis(pressed_point.x, X_OFFSET, X_LAST);
	assign y_mapped = map_axis(pressed_point.y, Y_OFFSET, Y_LAST);

	// touched rides along, delayed by the same edge as the data
	always_ff @(posedge tft_new_frame) begin
		if (!rst_n) begin
			scaled_point.x <= '0;
			scaled_point.y <= '0;
			scaled_point.touched <= 1'b0;
		end else begin
			scaled_point.x <= x_mapped;
			scaled_point.y <= y_mapped;
			scaled_point.touched <= pressed_point.touched;
		end
	end

endmodule

//--- hdl/touch_position_hold.sv
module touch_position_hold (
	input logic tft_new_frame,
	input logic rst_n,
	input touch_pkg::touch_point_t scaled_point,
	output touch_pkg::touch_point_t cursor
);

	// the touched level always follows, one frame late
	always_ff @(posedge tft_new_frame) begin
		if (!rst_n) begin
			cursor.touched <= 1'b0;
		end else begin
			cursor.touched <= scaled_point.touched;
		end
	end

	// position only moves while the pad is pressed
	// after release the last touched point stays on screen
	always_ff @(posedge tft_new_frame) begin
		if (!rst_n) begin
			cursor.x <= '0;
			cursor.y <= '0;
		end else if (scaled_point.touched) begin
			cursor.x <= scaled_point.x;
			cursor.y <= scaled_point.y;
		end
	end

endmodule

//--- hdl/touch_frame_pipeline.sv
module touch_frame_pipeline (
	input logic tft_new_frame,
	input logic rst_n,
	input touch_pkg::touch_sample_t raw_sample,
	output touch_pkg::touch_point_t cursor
);

	import touch_pkg::*;

	// raw position with the debounced touched level
	touch_point_t pressed_point;

	// calibrated, panel-clamped position
	touch_point_t scaled_point;

	// stage 1, presence and debounce
	touch_presence_detect i_touch_presence_detect (
		.tft_new_frame (tft_new_frame),
		.rst_n (rst_n),
		.raw_sample (raw_sample),
		.pressed_point (pressed_point)
	);

	// stage 2, offset, scale, clamp
	touch_offset_scale i_touch_offset_scale (
		.tft_new_frame (tft_new_frame),
		.rst_n (rst_n),
		.pressed_point (pressed_point),
		.scaled_point (scaled_point)
	);

	// stage 3, lock and hold
	touch_position_hold i_touch_position_hold (
		.tft_new_frame (tft_new_frame),
		.rst_n (rst_n),
		.scaled_point (scaled_point),
		.cursor (cursor)
	);

endmodule

//--- bench/touch_pipeline_assertions.sv
`include "touch_defs.svh"

module touch_pipeline_assertions (
	input logic tft_new_frame,
	input logic rst_n,
	input touch_pkg::touch_point_t scaled_point,
	input touch_pkg::touch_point_t cursor
);

	int failures = 0;

	// cursor stays on the visible panel
	a_x_on_panel: assert property (@(posedge tft_new_frame) disable iff (!rst_n)
		cursor.x < `SCREEN_WIDTH)
	else begin
		failures++;
		$error("cursor x past the last column");
	end

	a_y_on_panel: assert property (@(posedge tft_new_frame) disable iff (!rst_n)
		cursor.y < `SCREEN_HEIGHT)
	else begin
		failures++;
		$error("cursor y past the last row");
	end

	// a reset edge leaves everything cleared
	a_reset_clear: assert property (@(posedge tft_new_frame)
		!$past(rst_n) |-> cursor == '0)
	else begin
		failures++;
		$error("cursor not cleared by reset");
	end

	// untouched stage 3 input means the position stays locked
	a_hold_position: assert property (@(posedge tft_new_frame) disable iff (!rst_n)
		$past(rst_n) && !$past(scaled_point.touched) |-> $stable(cursor.x) && $stable(cursor.y))
	else begin
		failures++;
		$error("cursor moved while the pad was released");
	end

endmodule

bind touch_frame_pipeline touch_pipeline_assertions i_touch_pipeline_assertions (
	.tft_new_frame (tft_new_frame),
	.rst_n (rst_n),
	.scaled_point (scaled_point),
	.cursor (cursor)
);

//--- bench/touch_frame_pipeline_tb.sv
`include "touch_defs.svh"

module touch_frame_pipeline_tb;

	import touch_pkg::*;

	localparam int RESET_CYCLES = 5;
	localparam int IDLE_FRAMES = 12;
	localparam int DEBOUNCE_TEST_FRAMES = 15;
	localparam int MAP_HOLD = 5;
	localparam int MAP_POINTS = 4;
	localparam int HOLD_TEST_FRAMES = 10;
	localparam int RANDOM_RUNS = 60;
	// each random run lasts at most four frames
	localparam int CYCLE_LIMIT = RESET_CYCLES + IDLE_FRAMES + DEBOUNCE_TEST_FRAMES
		+ (MAP_POINTS + 2) * MAP_HOLD + HOLD_TEST_FRAMES + RANDOM_RUNS * 4 + 50;

	logic tft_new_frame = 1'b0;
	logic rst_n = 1'b0;
	touch_sample_t raw_sample = '0;
	touch_point_t cursor;

	logic [23:0] lfsr_state = 24'd88754;
	int error_count = 0;
	int check_count = 0;
	int cycle_count = 0;

	// reference pipeline, one register per stage
	int model_run = 0;
	touch_point_t model_s1 = '0;
	touch_point_t model_s2 = '0;
	touch_point_t model_cursor = '0;

	touch_frame_pipeline i_touch_frame_pipeline (
		.tft_new_frame (tft_new_frame),
		.rst_n (rst_n),
		.raw_sample (raw_sample),
		.cursor (cursor)
	);

	always #10 tft_new_frame = ~tft_new_frame;

	// x^24 + x^23 + x^22 + x^17 + 1
	function automatic logic [23:0] lfsr_step(input logic [23:0] state);
		logic feedback;
		feedback = state[23] ^ state[22] ^ state[21] ^ state[16];
		return {state[22:0], feedback};
	endfunction

	task automatic take_bits(input int count, output coord_t value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[10:0], lfsr_state[0]};
		end
	endtask

	// raw units to pixel index, pinned to the panel edges
	function automatic int expected_axis(input int raw, input int offset, input int size);
		int pixel;
		if (raw <= offset) begin
			return 0;
		end
		pixel = (raw - offset) / (1 << `TOUCH_SCALE_SHIFT);
		if (pixel > size - 1) begin
			return size - 1;
		end
		return pixel;
	endfunction

	always @(posedge tft_new_frame) begin : reference_model
		int run_next;
		logic pressed;
		if (!rst_n) begin
			model_run <= 0;
			model_s1 <= '0;
			model_s2 <= '0;
			model_cursor <= '0;
		end else begin
			pressed = int'(raw_sample.z) >= (1 << `TOUCH_Z_SHIFT);
			if (!pressed) begin
				run_next = 0;
			end else if (model_run < `DEBOUNCE_FRAMES) begin
				run_next = model_run + 1;
			end else begin
				run_next = model_run;
			end
			model_run <= run_next;
			model_s1.x <= raw_sample.x;
			model_s1.y <= raw_sample.y;
			model_s1.touched <= pressed && (run_next >= `DEBOUNCE_FRAMES);
			model_s2.x <= coord_t'(expected_axis(int'(model_s1.x), `TOUCH_X_OFFSET,
				`SCREEN_WIDTH));
			model_s2.y <= coord_t'(expected_axis(int'(model_s1.y), `TOUCH_Y_OFFSET,
				`SCREEN_HEIGHT));
			model_s2.touched <= model_s1.touched;
			model_cursor.touched <= model_s2.touched;
			if (model_s2.touched) begin
				model_cursor.x <= model_s2.x;
				model_cursor.y <= model_s2.y;
			end
		end
	end

	task automatic check_equal(input string name, input coord_t expected, input coord_t actual);
		check_count++;
		if (expected != actual) begin
			error_count++;
			$display("FAIL %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	// one frame of stimulus, then compare against the model mid-cycle
	task automatic drive_frame(input string name, input coord_t px, input coord_t py,
		input pressure_t pz);
		@(posedge tft_new_frame);
		raw_sample.x <= px;
		raw_sample.y <= py;
		raw_sample.z <= pz;
		@(negedge tft_new_frame);
		check_equal({name, " x"}, model_cursor.x, cursor.x);
		check_equal({name, " y"}, model_cursor.y, cursor.y);
		check_equal({name, " touched"}, coord_t'(model_cursor.touched),
			coord_t'(cursor.touched));
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("test %s done, %0d mismatches", name, error_count - errors_before);
	endtask

	task automatic test_idle();
		int errors_before;
		coord_t rx;
		coord_t ry;
		coord_t rz;
		errors_before = error_count;
		for (int i = 0; i < IDLE_FRAMES; i++) begin
			take_bits(12, rx);
			take_bits(12, ry);
			// 8 bits keeps the pressure under the threshold
			take_bits(8, rz);
			drive_frame("idle", rx, ry, rz);
			check_equal("idle x", '0, cursor.x);
			check_equal("idle y", '0, cursor.y);
			check_equal("idle touched", '0, coord_t'(cursor.touched));
		end
		report_test("idle", errors_before);
	endtask

	task automatic test_debounce();
		int errors_before;
		// lone press at frame 3, pair at frames 8 and 9
		logic [14:0] press_map = 15'h308;
		errors_before = error_count;
		for (int i = 0; i < DEBOUNCE_TEST_FRAMES; i++) begin
			drive_frame("debounce", 12'd1000, 12'd1000, press_map[i] ? 12'h800 : 12'h0ff);
			// second press of the pair reaches the cursor three frames on
			check_equal("debounce touched", coord_t'(i == 12), coord_t'(cursor.touched));
		end
		report_test("debounce", errors_before);
	endtask

	task automatic test_mapping();
		int errors_before;
		coord_t xs[MAP_POINTS] = '{12'd160, 12'd1000, 12'd1800, 12'd2050};
		coord_t ys[MAP_POINTS] = '{12'd310, 12'd700, 12'd1200, 12'd1380};
		errors_before = error_count;
		for (int p = 0; p < MAP_POINTS; p++) begin
			for (int f = 0; f < MAP_HOLD; f++) begin
				drive_frame("mapping", xs[p], ys[p], 12'hc00);
			end
			check_equal("mapping x", coord_t'(expected_axis(int'(xs[p]), `TOUCH_X_OFFSET,
				`SCREEN_WIDTH)), cursor.x);
			check_equal("mapping y", coord_t'(expected_axis(int'(ys[p]), `TOUCH_Y_OFFSET,
				`SCREEN_HEIGHT)), cursor.y);
			check_equal("mapping touched", 12'd1, coord_t'(cursor.touched));
		end
		report_test("mapping", errors_before);
	endtask

	task automatic test_clamping();
		int errors_before;
		errors_before = error_count;
		for (int f = 0; f < MAP_HOLD; f++) begin
			drive_frame("clamp low", 12'd100, 12'd200, 12'h900);
		end
		check_equal("clamp low x", 12'd0, cursor.x);
		check_equal("clamp low y", 12'd0, cursor.y);
		for (int f = 0; f < MAP_HOLD; f++) begin
			drive_frame("clamp high", 12'd4095, 12'd4095, 12'h900);
		end
		check_equal("clamp high x", 12'd479, cursor.x);
		check_equal("clamp high y", 12'd271, cursor.y);
		report_test("clamping", errors_before);
	endtask

	task automatic test_hold();
		int errors_before;
		errors_before = error_count;
		for (int i = 0; i < HOLD_TEST_FRAMES; i++) begin
			// released frames carry coordinates that must be ignored
			if (i < 4) begin
				drive_frame("hold", 12'd1200, 12'd900, 12'hfff);
			end else begin
				drive_frame("hold", 12'd3000, 12'd2000, 12'h050);
			end
			check_equal("hold touched", coord_t'(i <= 6), coord_t'(cursor.touched));
			if (i >= 3) begin
				check_equal("hold x", 12'd262, cursor.x);
				check_equal("hold y", 12'd150, cursor.y);
			end
		end
		report_test("hold", errors_before);
	endtask

	task automatic test_random();
		int errors_before;
		coord_t rx;
		coord_t ry;
		coord_t rz;
		coord_t pick;
		coord_t run_len;
		errors_before = error_count;
		for (int r = 0; r < RANDOM_RUNS; r++) begin
			take_bits(12, rx);
			take_bits(12, ry);
			take_bits(1, pick);
			take_bits(2, run_len);
			if (pick[0]) begin
				take_bits(12, rz);
				rz = rz | 12'h100;
			end else begin
				take_bits(8, rz);
			end
			for (int f = 0; f <= int'(run_len); f++) begin
				drive_frame("random", rx, ry, rz);
			end
		end
		report_test("random", errors_before);
	endtask

	// watchdog on frame clocks
	initial begin
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge tft_new_frame);
			cycle_count++;
		end
		$display("run timed out after %0d frame clocks before the tests ended", cycle_count);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		int assert_failures;
		repeat (RESET_CYCLES) @(posedge tft_new_frame);
		rst_n <= 1'b1;
		test_idle();
		test_debounce();
		test_mapping();
		test_clamping();
		test_hold();
		test_random();
		assert_failures = i_touch_frame_pipeline.i_touch_pipeline_assertions.failures;
		$display("checks %0d, mismatches %0d, assertion failures %0d",
			check_count, error_count, assert_failures);
		if (error_count == 0 && assert_failures == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- filelist.f
+incdir+hdl
hdl/touch_pkg.sv
hdl/touch_presence_detect.sv
hdl/touch_offset_scale.sv
hdl/touch_position_hold.sv
hdl/touch_frame_pipeline.sv
bench/touch_pipeline_assertions.sv
bench/touch_frame_pipeline_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP := touch_frame_pipeline_tb
FILELIST := filelist.f
VFLAGS := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
SIM_ARGS := +verilator+error+limit+1000
OBJ_DIR := obj_dir
LOG := sim.log
PASS_MSG := Finished with no errors

BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)

.PHONY: all run lint clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
